/* filelist.f */
+incdir+verilog
+incdir+testbench
verilog/alu_pkg.sv
verilog/alu_arith.sv
verilog/alu_logic.sv
verilog/alu_shift.sv
verilog/alu_writeback.sv
verilog/alu_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the ALU testbench with Verilator, run it and look for the verdict in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f filelist.f -o tb_sim &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

/* testbench/tb_vectors.svh */
// ALU test vectors
// One row per operation in issue order, holding op, width, op0, op1, the
// expected result at the width and the expected flag byte (S Z 0 H 0 V N C).
// Each row's flags follow on from the row before, since ADC, SBC, RL,
// RR, CCF and the flag-preserving ops depend on them.

typedef struct packed {
    alu_pkg::alu_op_t       op;
    alu_pkg::alu_width_t    w;
    logic [`ALU_DATA_W-1:0] op0;
    logic [`ALU_DATA_W-1:0] op1;
    logic [`ALU_DATA_W-1:0] res;
    logic [`ALU_FLAG_W-1:0] flg;
} vector_t;

localparam int NUM_ROWS = 34;

localparam vector_t VECTORS [NUM_ROWS] = '{
    '{alu_pkg::ALU_ADD, alu_pkg::W_BYTE, 32'h12345678, 32'h00000088, 32'h00000000, 8'h51},
    '{alu_pkg::ALU_ADC, alu_pkg::W_BYTE, 32'h0000007f, 32'h00000000, 32'h00000080, 8'h94},
    '{alu_pkg::ALU_ADD, alu_pkg::W_WORD, 32'h00008000, 32'h00008000, 32'h00000000, 8'h45},
    '{alu_pkg::ALU_ADC, alu_pkg::W_WORD, 32'h00001234, 32'h00000fcb, 32'h00002200, 8'h10},
    '{alu_pkg::ALU_ADD, alu_pkg::W_LONG, 32'hffffffff, 32'h00000001, 32'h00000000, 8'h51},
    '{alu_pkg::ALU_ADC, alu_pkg::W_LONG, 32'h7fffffff, 32'h00000000, 32'h80000000, 8'h94},
    '{alu_pkg::ALU_SUB, alu_pkg::W_BYTE, 32'h00000010, 32'h00000020, 32'h000000f0, 8'h83},
    '{alu_pkg::ALU_SBC, alu_pkg::W_BYTE, 32'h00000080, 32'h00000000, 32'h0000007f, 8'h16},
    '{alu_pkg::ALU_SUB, alu_pkg::W_WORD, 32'h00001000, 32'h00000001, 32'h00000fff, 8'h12},
    '{alu_pkg::ALU_SBC, alu_pkg::W_WORD, 32'h00005555, 32'h00005555, 32'h00000000, 8'h42},
    '{alu_pkg::ALU_CP,  alu_pkg::W_LONG, 32'h00000001, 32'h00000002, 32'h00000000, 8'h93},
    '{alu_pkg::ALU_SUB, alu_pkg::W_LONG, 32'h80000000, 32'h00000001, 32'h7fffffff, 8'h16},
    '{alu_pkg::ALU_CP,  alu_pkg::W_BYTE, 32'h00000042, 32'h00000052, 32'h00000000, 8'h83},
    '{alu_pkg::ALU_AND, alu_pkg::W_BYTE, 32'h0000f0f3, 32'h0000003c, 32'h00000030, 8'h14},
    '{alu_pkg::ALU_OR,  alu_pkg::W_WORD, 32'h00008001, 32'h00000100, 32'h00008101, 8'h80},
    '{alu_pkg::ALU_XOR, alu_pkg::W_LONG, 32'hffff00ff, 32'hffff00ff, 32'h00000000, 8'h44},
    '{alu_pkg::ALU_XOR, alu_pkg::W_BYTE, 32'h0000005a, 32'h000000ff, 32'h000000a5, 8'h84},
    '{alu_pkg::ALU_SCF, alu_pkg::W_BYTE, 32'h00000000, 32'h00000000, 32'h00000000, 8'h85},
    '{alu_pkg::ALU_RL,  alu_pkg::W_BYTE, 32'h00000040, 32'h00000000, 32'h00000081, 8'h84},
    '{alu_pkg::ALU_RLC, alu_pkg::W_BYTE, 32'h00000081, 32'h00000000, 32'h00000003, 8'h05},
    '{alu_pkg::ALU_RR,  alu_pkg::W_WORD, 32'h00000002, 32'h00000000, 32'h00008001, 8'h84},
    '{alu_pkg::ALU_RRC, alu_pkg::W_WORD, 32'h00000001, 32'h00000000, 32'h00008000, 8'h81},
    '{alu_pkg::ALU_SLA, alu_pkg::W_BYTE, 32'h000000c1, 32'h00000000, 32'h00000082, 8'h85},
    '{alu_pkg::ALU_SRA, alu_pkg::W_BYTE, 32'h00000085, 32'h00000000, 32'h000000c2, 8'h81},
    '{alu_pkg::ALU_SLL, alu_pkg::W_WORD, 32'h00008000, 32'h00000000, 32'h00000000, 8'h45},
    '{alu_pkg::ALU_SRL, alu_pkg::W_WORD, 32'h00008002, 32'h00000000, 32'h00004001, 8'h04},
    '{alu_pkg::ALU_BIT, alu_pkg::W_BYTE, 32'h00000010, 32'h00000004, 32'h00000000, 8'h14},
    '{alu_pkg::ALU_BIT, alu_pkg::W_BYTE, 32'h00000010, 32'h00000003, 32'h00000000, 8'h54},
    '{alu_pkg::ALU_SET, alu_pkg::W_WORD, 32'h00000000, 32'h0000000f, 32'h00008000, 8'h54},
    '{alu_pkg::ALU_RES, alu_pkg::W_WORD, 32'h0000ffff, 32'h00000000, 32'h0000fffe, 8'h54},
    '{alu_pkg::ALU_CHG, alu_pkg::W_BYTE, 32'h0000000f, 32'h00000007, 32'h0000008f, 8'h54},
    '{alu_pkg::ALU_CCF, alu_pkg::W_BYTE, 32'h00000000, 32'h00000000, 32'h00000000, 8'h55},
    '{alu_pkg::ALU_RCF, alu_pkg::W_BYTE, 32'h00000000, 32'h00000000, 32'h00000000, 8'h44},
    '{alu_pkg::ALU_SCF, alu_pkg::W_BYTE, 32'h00000000, 32'h00000000, 32'h00000000, 8'h45}
};

/* testbench/tb_top.sv */
// ALU testbench top
// Drives the vector table into the ALU with random idle cycles between
// rows, and ends the run on the checker's counts or on a timeout.

`include "alu_cfg.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_vectors.svh"

    // every row plus at most one idle cycle, reset and some margin
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 2 + 5 + 20;

    logic                   clk = 1'b0;
    logic                   rst;
    alu_pkg::alu_op_t       op;
    alu_pkg::alu_width_t    w;
    logic [`ALU_DATA_W-1:0] op0, op1, dout;
    logic [`ALU_FLAG_W-1:0] flags;
    alu_pkg::alu_width_t    res_we;
    int                     errors, checks, rows_checked;

    always #5 clk = ~clk;

    alu_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .op0    (op0),
        .op1    (op1),
        .op     (op),
        .w      (w),
        .dout   (dout),
        .flags  (flags),
        .res_we (res_we)
    );

    tb_checker chk0 (
        .clk          (clk),
        .rst          (rst),
        .w            (w),
        .dout         (dout),
        .flags        (flags),
        .res_we       (res_we),
        .errors       (errors),
        .checks       (checks),
        .rows_checked (rows_checked)
    );

    initial begin
        int i;
        rst = 1'b1;
        op  = alu_pkg::ALU_ADD;
        w   = alu_pkg::W_NONE;
        op0 = '0;
        op1 = '0;
        void'($urandom(32'hf2e732e9));
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (i = 0; i < NUM_ROWS; i++) begin
            if ($urandom % 4 == 0) begin // idle cycle, operands change but w stays zero
                w   <= alu_pkg::W_NONE;
                op0 <= $urandom;
                op1 <= $urandom;
                @(posedge clk);
            end
            op  <= VECTORS[i].op;
            w   <= VECTORS[i].w;
            op0 <= VECTORS[i].op0;
            op1 <= VECTORS[i].op1;
            @(posedge clk);
        end
        w <= alu_pkg::W_NONE;
        wait (rows_checked == NUM_ROWS);
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * 10);
        $display("timeout after %0d cycles with %0d of %0d rows checked",
                 TIMEOUT_CYCLES, rows_checked, NUM_ROWS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* testbench/tb_checker.sv */
// ALU response checker
// Follows each operation issued to the ALU, compares the result, flags
// and write strobe a cycle later against the vector table, and makes
// sure reset and idle cycles leave everything unchanged.

`include "alu_cfg.svh"

module tb_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  alu_pkg::alu_width_t    w,
    input  logic [`ALU_DATA_W-1:0] dout,
    input  logic [`ALU_FLAG_W-1:0] flags,
    input  alu_pkg::alu_width_t    res_we,
    output int                     errors,
    output int                     checks,
    output int                     rows_checked
);
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_vectors.svh"

    int                     err_cnt = 0;
    int                     chk_cnt = 0;
    int                     done_cnt = 0;
    int                     next_row = 0;
    int                     cur_row = 0;
    logic                   was_op = 1'b0;
    logic [`ALU_DATA_W-1:0] last_dout = '0;
    logic [`ALU_FLAG_W-1:0] last_flags = '0;

    assign errors       = err_cnt;
    assign checks       = chk_cnt;
    assign rows_checked = done_cnt;

    function automatic logic [`ALU_DATA_W-1:0] width_mask(input alu_pkg::alu_width_t wd);
        if (wd[0])
            return 32'h0000_00ff;
        else if (wd[1])
            return 32'h0000_ffff;
        return 32'hffff_ffff;
    endfunction

    // flag-only operations
    function automatic bit writes_result(input alu_pkg::alu_op_t o);
        return !(o inside {alu_pkg::ALU_CP, alu_pkg::ALU_BIT, alu_pkg::ALU_SCF,
                           alu_pkg::ALU_RCF, alu_pkg::ALU_CCF});
    endfunction

    task automatic compare(input string ctx, input string name,
                           input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s %s: got 0x%h, expected 0x%h", name, ctx, got, exp);
        end
    endtask

    task automatic check_row(input int r);
        alu_pkg::alu_width_t    exp_we;
        logic [`ALU_DATA_W-1:0] mask;
        string                  ctx;
        exp_we = writes_result(VECTORS[r].op) ? VECTORS[r].w : alu_pkg::W_NONE;
        mask   = width_mask(VECTORS[r].w);
        ctx    = $sformatf("at row %0d", r);
        compare(ctx, "res_we", 32'(res_we), 32'(exp_we));
        if (exp_we != alu_pkg::W_NONE)
            compare(ctx, "dout", dout & mask, VECTORS[r].res & mask);
        else
            compare(ctx, "dout", dout, last_dout); // no write, old result stays
        compare(ctx, "flags", 32'(flags), 32'(VECTORS[r].flg));
        done_cnt++;
    endtask

    task automatic check_idle(input string ctx);
        compare(ctx, "res_we", 32'(res_we), 32'd0);
        compare(ctx, "dout", dout, last_dout);
        compare(ctx, "flags", 32'(flags), 32'(last_flags));
    endtask

    // negedge sampling, outputs settled since the last rising edge
    always @(negedge clk) begin
        if (rst) begin
            last_dout  = '0;
            last_flags = '0;
            check_idle("in reset");
            was_op = 1'b0;
        end else begin
            if (was_op)
                check_row(cur_row);
            else
                check_idle("after an idle cycle");
            last_dout  = dout;
            last_flags = flags;
            was_op     = w != alu_pkg::W_NONE && next_row < NUM_ROWS;
            if (was_op) begin
                cur_row  = next_row;
                next_row = next_row + 1;
            end
        end
    end

endmodule

/* verilog/alu_top.sv */
// ALU top level
// Connects the add/subtract, logic and shift units to the result and
// flag register. Results and flags appear one clock after the operands.

`include "alu_cfg.svh"

module alu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`ALU_DATA_W-1:0] op0,
    input  logic [`ALU_DATA_W-1:0] op1,
    input  alu_pkg::alu_op_t       op,
    input  alu_pkg::alu_width_t    w,
    output logic [`ALU_DATA_W-1:0] dout,
    output logic [`ALU_FLAG_W-1:0] flags,
    output alu_pkg::alu_width_t    res_we
);

    logic [`ALU_DATA_W-1:0] arith_sum, logic_result, shift_result;
    logic                   arith_half, arith_carry, arith_overflow;
    logic                   tested_bit, shift_out, carry_flag;

    alu_arith u_arith (
        .op0        (op0),
        .op1        (op1),
        .op         (op),
        .w          (w),
        .carry_in   (carry_flag),
        .sum        (arith_sum),
        .half_carry (arith_half),
        .carry      (arith_carry),
        .overflow   (arith_overflow)
    );

    alu_logic u_logic (
        .op0        (op0),
        .op1        (op1),
        .op         (op),
        .result     (logic_result),
        .tested_bit (tested_bit)
    );

    alu_shift u_shift (
        .op0        (op0),
        .op         (op),
        .w          (w),
        .carry_in   (carry_flag),
        .result     (shift_result),
        .shift_out  (shift_out)
    );

    alu_writeback u_writeback (
        .clk            (clk),
        .rst            (rst),
        .op             (op),
        .w              (w),
        .arith_sum      (arith_sum),
        .arith_half     (arith_half),
        .arith_carry    (arith_carry),
        .arith_overflow (arith_overflow),
        .logic_result   (logic_result),
        .tested_bit     (tested_bit),
        .shift_result   (shift_result),
        .shift_out      (shift_out),
        .carry_flag     (carry_flag),
        .dout           (dout),
        .flags          (flags),
        .res_we         (res_we)
    );

endmodule

/* verilog/alu_writeback.sv */
// ALU result and flag register
// Picks the result of the unit that serves the current operation, works
// out sign, zero and parity at the operand width, applies the flag update
// for the operation and registers dout, the flag byte and the write strobe.

`include "alu_cfg.svh"

module alu_writeback (
    input  logic                   clk,
    input  logic                   rst,
    input  alu_pkg::alu_op_t       op,
    input  alu_pkg::alu_width_t    w,
    input  logic [`ALU_DATA_W-1:0] arith_sum,
    input  logic                   arith_half,
    input  logic                   arith_carry,
    input  logic                   arith_overflow,
    input  logic [`ALU_DATA_W-1:0] logic_result,
    input  logic                   tested_bit,
    input  logic [`ALU_DATA_W-1:0] shift_result,
    input  logic                   shift_out,
    output logic                   carry_flag,
    output logic [`ALU_DATA_W-1:0] dout,
    output logic [`ALU_FLAG_W-1:0] flags,
    output alu_pkg::alu_width_t    res_we
);

    logic [`ALU_DATA_W-1:0] rslt;
    logic [`ALU_FLAG_W-1:0] nx_flags;
    logic                   is_arith, is_logic, is_bitop, is_shift, writes;
    logic                   r_sign, r_zero, r_even;
    alu_pkg::alu_width_t    nx_we;

    assign is_arith = op inside {alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_SUB,
                                 alu_pkg::ALU_SBC, alu_pkg::ALU_CP};
    assign is_logic = op inside {alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR};
    assign is_bitop = op inside {alu_pkg::ALU_SET, alu_pkg::ALU_RES, alu_pkg::ALU_CHG};
    assign is_shift = op inside {alu_pkg::ALU_RL, alu_pkg::ALU_RR, alu_pkg::ALU_RLC,
                                 alu_pkg::ALU_RRC, alu_pkg::ALU_SLA, alu_pkg::ALU_SRA,
                                 alu_pkg::ALU_SLL, alu_pkg::ALU_SRL};

    // CP, BIT and the carry-flag ops only touch the flags
    assign writes = (is_arith && op != alu_pkg::ALU_CP) || is_logic || is_bitop || is_shift;
    assign nx_we  = writes ? w : alu_pkg::W_NONE;

    assign rslt = is_arith              ? arith_sum    :
                  is_logic || is_bitop  ? logic_result :
                  is_shift              ? shift_result : dout;

    assign r_sign = w[0] ? rslt[7] : w[1] ? rslt[15] : rslt[31];
    assign r_zero = w[0] ? rslt[7:0] == 8'd0 : w[1] ? rslt[15:0] == 16'd0 : rslt == '0;
    assign r_even = w[0] ? ~^rslt[7:0] : ~^rslt[15:0]; // V for logic and shifts

    assign carry_flag = flags[alu_pkg::FLAG_C];

    always_comb begin
        nx_flags = flags;
        if (is_arith) begin
            nx_flags[alu_pkg::FLAG_S] = r_sign;
            nx_flags[alu_pkg::FLAG_Z] = r_zero;
            nx_flags[alu_pkg::FLAG_H] = arith_half;
            nx_flags[alu_pkg::FLAG_V] = arith_overflow;
            nx_flags[alu_pkg::FLAG_N] = op != alu_pkg::ALU_ADD && op != alu_pkg::ALU_ADC;
            nx_flags[alu_pkg::FLAG_C] = arith_carry;
        end else if (is_logic || is_shift) begin
            nx_flags[alu_pkg::FLAG_S] = r_sign;
            nx_flags[alu_pkg::FLAG_Z] = r_zero;
            nx_flags[alu_pkg::FLAG_H] = op == alu_pkg::ALU_AND;
            nx_flags[alu_pkg::FLAG_V] = r_even;
            nx_flags[alu_pkg::FLAG_N] = 1'b0;
            nx_flags[alu_pkg::FLAG_C] = is_shift & shift_out;
        end else begin
            case (op)
                alu_pkg::ALU_BIT: begin
                    nx_flags[alu_pkg::FLAG_Z] = ~tested_bit;
                    nx_flags[alu_pkg::FLAG_H] = 1'b1;
                    nx_flags[alu_pkg::FLAG_N] = 1'b0;
                end
                alu_pkg::ALU_SCF, alu_pkg::ALU_RCF: begin
                    nx_flags[alu_pkg::FLAG_C] = op == alu_pkg::ALU_SCF;
                    nx_flags[alu_pkg::FLAG_H] = 1'b0;
                    nx_flags[alu_pkg::FLAG_N] = 1'b0;
                end
                alu_pkg::ALU_CCF: begin
                    nx_flags[alu_pkg::FLAG_C] = ~flags[alu_pkg::FLAG_C];
                    nx_flags[alu_pkg::FLAG_N] = 1'b0;
                end
                default: ; // SET, RES and CHG keep the flags
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            flags  <= '0;
            res_we <= alu_pkg::W_NONE;
        end else begin
            res_we <= nx_we;
            if (nx_we != alu_pkg::W_NONE)
                dout <= rslt;
            if (w != alu_pkg::W_NONE) // idle cycles leave the flags alone
                flags <= nx_flags;
        end
    end

endmodule

/* verilog/alu_shift.sv */
// ALU shifter
// One-position rotates and shifts at byte, word or long width. The bit
// entering at the free end is the old carry, the sign bit, the wrapped
// bit or zero depending on the operation; the bit pushed out is reported.

`include "alu_cfg.svh"

module alu_shift (
    input  logic [`ALU_DATA_W-1:0] op0,
    input  alu_pkg::alu_op_t       op,
    input  alu_pkg::alu_width_t    w,
    input  logic                   carry_in,
    output logic [`ALU_DATA_W-1:0] result,
    output logic                   shift_out
);

    logic op0_s, msb_in, lsb_in, left;

    assign op0_s = w[0] ? op0[7] : w[1] ? op0[15] : op0[31]; // msb at width

    assign left = op == alu_pkg::ALU_RL  || op == alu_pkg::ALU_RLC ||
                  op == alu_pkg::ALU_SLA || op == alu_pkg::ALU_SLL;

    assign msb_in = op == alu_pkg::ALU_RR  ? carry_in :
                    op == alu_pkg::ALU_SRA ? op0_s    :
                    op == alu_pkg::ALU_RRC ? op0[0]   : 1'b0;

    assign lsb_in = op == alu_pkg::ALU_RL  ? carry_in :
                    op == alu_pkg::ALU_RLC ? op0_s    : 1'b0;

    always_comb begin
        result = op0;
        if (left) begin
            shift_out = op0_s;
            if (w[0])
                result[7:0] = {op0[6:0], lsb_in};
            else if (w[1])
                result[15:0] = {op0[14:0], lsb_in};
            else
                result = {op0[30:0], lsb_in};
        end else begin
            shift_out = op0[0];
            if (w[0])
                result[7:0] = {msb_in, op0[7:1]};
            else if (w[1])
                result[15:0] = {msb_in, op0[15:1]};
            else
                result = {msb_in, op0[31:1]};
        end
    end

endmodule

/* verilog/alu_logic.sv */
// ALU logic unit
// Bitwise AND, OR and XOR, and the single-bit SET, RES and CHG edits of
// op0 at the index held in the low bits of op1. The indexed bit of op0 is
// also given out for BIT.

`include "alu_cfg.svh"

module alu_logic (
    input  logic [`ALU_DATA_W-1:0] op0,
    input  logic [`ALU_DATA_W-1:0] op1,
    input  alu_pkg::alu_op_t       op,
    output logic [`ALU_DATA_W-1:0] result,
    output logic                   tested_bit
);

    logic [`ALU_BIT_IDX_W-1:0] idx;

    assign idx        = op1[`ALU_BIT_IDX_W-1:0];
    assign tested_bit = op0[idx]; // BIT reads op0 only

    always_comb begin
        result = op0;
        case (op)
            alu_pkg::ALU_AND: begin
                result = op0 & op1;
            end
            alu_pkg::ALU_OR: begin
                result = op0 | op1;
            end
            alu_pkg::ALU_XOR: begin
                result = op0 ^ op1;
            end
            alu_pkg::ALU_SET: begin
                result[idx] = 1'b1;
            end
            alu_pkg::ALU_RES: begin
                result[idx] = 1'b0;
            end
            alu_pkg::ALU_CHG: begin
                result[idx] = ~op0[idx];
            end
            default: begin
                result = op0;
            end
        endcase
    end

endmodule

/* verilog/alu_arith.sv */
// ALU adder and subtractor
// Adds or subtracts op1 from op0 with an optional carry for ADC/SBC.
// The nibble, byte, word and upper-half chain gives the half carry and
// the carry at each width; overflow comes from a sign-extended result.

`include "alu_cfg.svh"

module alu_arith (
    input  logic [`ALU_DATA_W-1:0] op0,
    input  logic [`ALU_DATA_W-1:0] op1,
    input  alu_pkg::alu_op_t       op,
    input  alu_pkg::alu_width_t    w,
    input  logic                   carry_in,
    output logic [`ALU_DATA_W-1:0] sum,
    output logic                   half_carry,
    output logic                   carry,
    output logic                   overflow
);

    logic [`ALU_DATA_W:0] ext0, ext1, ext_r;
    logic c4, c8, c16, c32;
    logic cin, is_sub, r_sign;

    function automatic logic [`ALU_DATA_W:0] extend(input logic [`ALU_DATA_W-1:0] x,
                                                     input alu_pkg::alu_width_t wd);
        if (wd[0])
            return {{25{x[7]}}, x[7:0]};
        else if (wd[1])
            return {{17{x[15]}}, x[15:0]};
        return {x[31], x};
    endfunction

    assign cin    = carry_in & (op == alu_pkg::ALU_ADC || op == alu_pkg::ALU_SBC);
    assign is_sub = op == alu_pkg::ALU_SUB || op == alu_pkg::ALU_SBC || op == alu_pkg::ALU_CP;
    assign ext0   = extend(op0, w);
    assign ext1   = extend(op1, w);

    always_comb begin
        if (is_sub) begin // top bit of each slice is the borrow
            {c4,  sum[3:0]}   = {1'b0, op0[3:0]}   - {1'b0, op1[3:0]}   - {4'd0, cin};
            {c8,  sum[7:4]}   = {1'b0, op0[7:4]}   - {1'b0, op1[7:4]}   - {4'd0, c4};
            {c16, sum[15:8]}  = {1'b0, op0[15:8]}  - {1'b0, op1[15:8]}  - {8'd0, c8};
            {c32, sum[31:16]} = {1'b0, op0[31:16]} - {1'b0, op1[31:16]} - {16'd0, c16};
            ext_r = ext0 - ext1 - {32'd0, cin};
        end else begin
            {c4,  sum[3:0]}   = {1'b0, op0[3:0]}   + {1'b0, op1[3:0]}   + {4'd0, cin};
            {c8,  sum[7:4]}   = {1'b0, op0[7:4]}   + {1'b0, op1[7:4]}   + {4'd0, c4};
            {c16, sum[15:8]}  = {1'b0, op0[15:8]}  + {1'b0, op1[15:8]}  + {8'd0, c8};
            {c32, sum[31:16]} = {1'b0, op0[31:16]} + {1'b0, op1[31:16]} + {16'd0, c16};
            ext_r = ext0 + ext1 + {32'd0, cin};
        end
    end

    assign r_sign     = w[0] ? sum[7] : w[1] ? sum[15] : sum[31];
    assign half_carry = c4;
    assign carry      = w[0] ? c8 : w[1] ? c16 : c32;
    assign overflow   = ext_r[`ALU_DATA_W] ^ r_sign; // true sign vs sign at width

endmodule

/* verilog/alu_pkg.sv */
// ALU package
// Operation codes, the one-hot operand width code and the bit positions
// of each flag inside the flag byte.

package alu_pkg;

    typedef enum logic [5:0] {
        ALU_ADD = 6'd0,
        ALU_ADC = 6'd1,
        ALU_SUB = 6'd2,
        ALU_SBC = 6'd3,
        ALU_CP  = 6'd4,
        ALU_AND = 6'd5,
        ALU_OR  = 6'd6,
        ALU_XOR = 6'd7,
        ALU_RL  = 6'd8,   // through carry
        ALU_RR  = 6'd9,   // through carry
        ALU_RLC = 6'd10,
        ALU_RRC = 6'd11,
        ALU_SLA = 6'd12,
        ALU_SRA = 6'd13,
        ALU_SLL = 6'd14,
        ALU_SRL = 6'd15,
        ALU_BIT = 6'd16,
        ALU_SET = 6'd17,
        ALU_RES = 6'd18,
        ALU_CHG = 6'd19,
        ALU_SCF = 6'd20,
        ALU_RCF = 6'd21,
        ALU_CCF = 6'd22
    } alu_op_t;

    // one-hot, zero means no operation this cycle
    typedef enum logic [2:0] {
        W_NONE = 3'b000,
        W_BYTE = 3'b001,
        W_WORD = 3'b010,
        W_LONG = 3'b100
    } alu_width_t;

    // positions 5 and 3 always read as zero
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

endpackage

/* verilog/alu_cfg.svh */
// ALU configuration constants
// Operand width, flag byte width and the bit-index width used by the
// single-bit operations.

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// operand and result width
`define ALU_DATA_W 32

// S Z 0 H 0 V N C
`define ALU_FLAG_W 8

// bit index taken from op1 for BIT, SET, RES and CHG
`define ALU_BIT_IDX_W 4

`endif
